/* project.f */
source/decode_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/operand_bypass.sv
source/branch_unit.sv
source/decode_stage.sv
test/decode_stage_assertions.sv
test/decode_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module decode_stage_tb -f project.f -o decode_stage_sim \
  && ./obj_dir/decode_stage_sim \
  || exit 1

/* source/branch_unit.sv */
`timescale 1ns/10ps
module branch_unit (
  input  decode_pkg::branch_kind_t kind,
  input  decode_pkg::word_t        pc,
  input  decode_pkg::word_t        br_offs,
  input  decode_pkg::word_t        jirl_offs,
  input  decode_pkg::word_t        rj_value,
  input  decode_pkg::word_t        rkd_value,
  input  logic                     id_valid,
  input  logic                     stall,
  output decode_pkg::branch_req_t  branch
);
  import decode_pkg::*;

  logic  rj_eq_rd;
  logic  rj_lt_rd;
  logic  rj_ltu_rd;
  logic  cond;
  word_t target;

  assign rj_eq_rd  = rj_value == rkd_value;
  assign rj_lt_rd  = $signed(rj_value) < $signed(rkd_value);
  assign rj_ltu_rd = rj_value < rkd_value;

  always_comb begin
    case (kind)
      br_b, br_bl, br_jirl: cond = 1'b1; // unconditional
      br_beq:  cond = rj_eq_rd;
      br_bne:  cond = !rj_eq_rd;
      br_blt:  cond = rj_lt_rd;
      br_bge:  cond = !rj_lt_rd;
      br_bltu: cond = rj_ltu_rd;
      br_bgeu: cond = !rj_ltu_rd;
      default: cond = 1'b0;
    endcase
  end

  assign target = (kind == br_jirl) ? rj_value + jirl_offs : pc + br_offs;

  assign branch = '{
    stall:  stall && (kind != br_none), // fetch must hold, outcome unknown
    taken:  cond && id_valid && !stall,
    target: target
  };

endmodule

/* source/decode_pkg.sv */
package decode_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;
  typedef logic [18:0]     alu_op_t;

  // bit positions inside alu_op_t
  localparam int alu_add   = 0;
  localparam int alu_sub   = 1;
  localparam int alu_slt   = 2;
  localparam int alu_sltu  = 3;
  localparam int alu_and   = 4;
  localparam int alu_nor   = 5;
  localparam int alu_or    = 6;
  localparam int alu_xor   = 7;
  localparam int alu_sll   = 8;
  localparam int alu_srl   = 9;
  localparam int alu_sra   = 10;
  localparam int alu_lui   = 11;
  localparam int alu_mul   = 12;
  localparam int alu_mulh  = 13;
  localparam int alu_mulhu = 14;
  localparam int alu_div   = 15;
  localparam int alu_divu  = 16;
  localparam int alu_mod   = 17;
  localparam int alu_modu  = 18;

  typedef struct packed {
    logic st_w;
    logic st_h;
    logic st_b;
    logic ld_w;
    logic ld_b;
    logic ld_h;
    logic ld_bu;
    logic ld_hu;
  } mem_op_t;

  typedef enum logic [3:0] {
    br_none, br_b, br_bl, br_jirl, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } branch_kind_t;

  // major opcode, inst[31:26]
  localparam logic [5:0] op6_alu       = 6'h00;
  localparam logic [5:0] op6_lu12i     = 6'h05;
  localparam logic [5:0] op6_pcaddu12i = 6'h07;
  localparam logic [5:0] op6_mem       = 6'h0a;
  localparam logic [5:0] op6_jirl      = 6'h13;
  localparam logic [5:0] op6_b         = 6'h14;
  localparam logic [5:0] op6_bl        = 6'h15;
  localparam logic [5:0] op6_beq       = 6'h16;
  localparam logic [5:0] op6_bne       = 6'h17;
  localparam logic [5:0] op6_blt       = 6'h18;
  localparam logic [5:0] op6_bge       = 6'h19;
  localparam logic [5:0] op6_bltu      = 6'h1a;
  localparam logic [5:0] op6_bgeu      = 6'h1b;

  // inst[25:22], alu group
  localparam logic [3:0] op4_reg   = 4'h0;
  localparam logic [3:0] op4_shift = 4'h1;
  localparam logic [3:0] op4_slti  = 4'h8;
  localparam logic [3:0] op4_sltui = 4'h9;
  localparam logic [3:0] op4_addi  = 4'ha;
  localparam logic [3:0] op4_andi  = 4'hd;
  localparam logic [3:0] op4_ori   = 4'he;
  localparam logic [3:0] op4_xori  = 4'hf;

  // inst[25:22], memory group
  localparam logic [3:0] op4_ld_b  = 4'h0;
  localparam logic [3:0] op4_ld_h  = 4'h1;
  localparam logic [3:0] op4_ld_w  = 4'h2;
  localparam logic [3:0] op4_st_b  = 4'h4;
  localparam logic [3:0] op4_st_h  = 4'h5;
  localparam logic [3:0] op4_st_w  = 4'h6;
  localparam logic [3:0] op4_ld_bu = 4'h8;
  localparam logic [3:0] op4_ld_hu = 4'h9;

  // inst[21:20]
  localparam logic [1:0] op2_shift  = 2'h0;
  localparam logic [1:0] op2_reg3   = 2'h1;
  localparam logic [1:0] op2_divmod = 2'h2;

  // inst[19:15]
  localparam logic [4:0] op5_add   = 5'h00;
  localparam logic [4:0] op5_sub   = 5'h02;
  localparam logic [4:0] op5_slt   = 5'h04;
  localparam logic [4:0] op5_sltu  = 5'h05;
  localparam logic [4:0] op5_nor   = 5'h08;
  localparam logic [4:0] op5_and   = 5'h09;
  localparam logic [4:0] op5_or    = 5'h0a;
  localparam logic [4:0] op5_xor   = 5'h0b;
  localparam logic [4:0] op5_sll   = 5'h0e;
  localparam logic [4:0] op5_srl   = 5'h0f;
  localparam logic [4:0] op5_sra   = 5'h10;
  localparam logic [4:0] op5_mul   = 5'h18;
  localparam logic [4:0] op5_mulh  = 5'h19;
  localparam logic [4:0] op5_mulhu = 5'h1a;
  localparam logic [4:0] op5_div   = 5'h00; // op2_divmod group
  localparam logic [4:0] op5_mod   = 5'h01;
  localparam logic [4:0] op5_divu  = 5'h02;
  localparam logic [4:0] op5_modu  = 5'h03;
  localparam logic [4:0] op5_slli  = 5'h01; // op2_shift group
  localparam logic [4:0] op5_srli  = 5'h09;
  localparam logic [4:0] op5_srai  = 5'h11;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_bundle_t;

  typedef struct packed {
    logic      rf_we;
    reg_addr_t waddr;
    word_t     wdata;
  } bypass_t;

  typedef struct packed {
    logic    res_from_mem; // load still in flight
    bypass_t wr;
  } ex_bypass_t;

  typedef struct packed {
    alu_op_t      alu_op;
    logic         src1_is_pc;
    logic         src2_is_imm;
    word_t        imm;
    reg_addr_t    rf_raddr1;
    reg_addr_t    rf_raddr2;
    logic         rf_we;
    reg_addr_t    dest;
    mem_op_t      mem_op;
    logic         res_from_mem;
    branch_kind_t branch_kind;
    word_t        br_offs;
  } decode_ctrl_t;

  typedef struct packed {
    logic  stall;
    logic  taken;
    word_t target;
  } branch_req_t;

  typedef struct packed {
    alu_op_t   alu_op;
    logic      res_from_mem;
    word_t     alu_src1;
    word_t     alu_src2;
    mem_op_t   mem_op;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rkd_value; // store data
    word_t     pc;
  } ex_bundle_t;

endpackage

/* source/decode_stage.sv */
`timescale 1ns/10ps
module decode_stage (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      fe_valid,
  input  decode_pkg::fetch_bundle_t fe_bundle,
  output logic                      allowin,
  input  logic                      ex_allowin,
  output logic                      ex_valid,
  output decode_pkg::ex_bundle_t    ex_bundle,
  output decode_pkg::branch_req_t   branch,
  input  decode_pkg::ex_bypass_t    ex_fwd,
  input  decode_pkg::bypass_t       mem_fwd,
  input  decode_pkg::bypass_t       wb_fwd
);
  import decode_pkg::*;

  logic          id_valid;
  fetch_bundle_t id_bundle;
  decode_ctrl_t  ctrl;
  word_t         rf_rdata1;
  word_t         rf_rdata2;
  word_t         rj_value;
  word_t         rkd_value;
  logic          need1;
  logic          need2;
  logic          stall;

  assign ex_valid = id_valid && !stall;
  assign allowin  = !id_valid || (!stall && ex_allowin);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id_valid <= 1'b0;
    end else if (branch.taken) begin
      id_valid <= 1'b0; // drop wrong-path slot
    end else if (allowin) begin
      id_valid <= fe_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fe_valid && allowin) begin
      id_bundle <= fe_bundle;
    end
  end

  instr_decoder u_decoder (
    .inst (id_bundle.inst),
    .ctrl (ctrl)
  );

  register_file u_regfile (
    .clk    (clk),
    .raddr1 (ctrl.rf_raddr1),
    .rdata1 (rf_rdata1),
    .raddr2 (ctrl.rf_raddr2),
    .rdata2 (rf_rdata2),
    .wr     (wb_fwd)
  );

  // operands matter only when the alu consumes them
  assign need1 = !ctrl.src1_is_pc && (|ctrl.alu_op);
  assign need2 = !ctrl.src2_is_imm && (|ctrl.alu_op);

  operand_bypass u_bypass (
    .raddr1    (ctrl.rf_raddr1),
    .raddr2    (ctrl.rf_raddr2),
    .need1     (need1),
    .need2     (need2),
    .rdata1    (rf_rdata1),
    .rdata2    (rf_rdata2),
    .ex_fwd    (ex_fwd),
    .mem_fwd   (mem_fwd),
    .wb_fwd    (wb_fwd),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .stall     (stall)
  );

  branch_unit u_branch (
    .kind      (ctrl.branch_kind),
    .pc        (id_bundle.pc),
    .br_offs   (ctrl.br_offs),
    .jirl_offs (ctrl.br_offs), // i16 form for jirl
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .id_valid  (id_valid),
    .stall     (stall),
    .branch    (branch)
  );

  assign ex_bundle = '{
    alu_op:       ctrl.alu_op,
    res_from_mem: ctrl.res_from_mem,
    alu_src1:     ctrl.src1_is_pc ? id_bundle.pc : rj_value,
    alu_src2:     ctrl.src2_is_imm ? ctrl.imm : rkd_value,
    mem_op:       ctrl.mem_op,
    rf_we:        ctrl.rf_we,
    rf_waddr:     ctrl.dest,
    rkd_value:    rkd_value,
    pc:           id_bundle.pc
  };

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/10ps
module instr_decoder (
  input  decode_pkg::word_t        inst,
  output decode_pkg::decode_ctrl_t ctrl
);
  import decode_pkg::*;

  logic [5:0]  op6;
  logic [3:0]  op4;
  logic [1:0]  op2;
  logic [4:0]  op5;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;

  logic grp_alu, grp_reg3, grp_divmod, grp_shift, grp_mem;
  logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
  logic inst_sll, inst_srl, inst_sra, inst_slli, inst_srli, inst_srai;
  logic inst_mul, inst_mulh, inst_mulhu, inst_div, inst_mod, inst_divu, inst_modu;
  logic inst_slti, inst_sltui, inst_addi, inst_andi, inst_ori, inst_xori;
  logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
  logic inst_st_b, inst_st_h, inst_st_w;
  logic inst_lu12i, inst_pcaddu12i, inst_jirl, inst_b, inst_bl;
  logic is_load, is_store, cond_br, need_si12, need_si20, src2_is_4;

  assign op6 = inst[31:26];
  assign op4 = inst[25:22];
  assign op2 = inst[21:20];
  assign op5 = inst[19:15];
  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i16 = inst[25:10];
  assign i20 = inst[24:5];
  assign i26 = {inst[9:0], inst[25:10]}; // offs[15:0] sits above offs[25:16]

  assign grp_alu    = op6 == op6_alu;
  assign grp_reg3   = grp_alu && (op4 == op4_reg) && (op2 == op2_reg3);
  assign grp_divmod = grp_alu && (op4 == op4_reg) && (op2 == op2_divmod);
  assign grp_shift  = grp_alu && (op4 == op4_shift) && (op2 == op2_shift);
  assign grp_mem    = op6 == op6_mem;

  assign inst_add   = grp_reg3 && (op5 == op5_add);
  assign inst_sub   = grp_reg3 && (op5 == op5_sub);
  assign inst_slt   = grp_reg3 && (op5 == op5_slt);
  assign inst_sltu  = grp_reg3 && (op5 == op5_sltu);
  assign inst_nor   = grp_reg3 && (op5 == op5_nor);
  assign inst_and   = grp_reg3 && (op5 == op5_and);
  assign inst_or    = grp_reg3 && (op5 == op5_or);
  assign inst_xor   = grp_reg3 && (op5 == op5_xor);
  assign inst_sll   = grp_reg3 && (op5 == op5_sll);
  assign inst_srl   = grp_reg3 && (op5 == op5_srl);
  assign inst_sra   = grp_reg3 && (op5 == op5_sra);
  assign inst_mul   = grp_reg3 && (op5 == op5_mul);
  assign inst_mulh  = grp_reg3 && (op5 == op5_mulh);
  assign inst_mulhu = grp_reg3 && (op5 == op5_mulhu);
  assign inst_div   = grp_divmod && (op5 == op5_div);
  assign inst_mod   = grp_divmod && (op5 == op5_mod);
  assign inst_divu  = grp_divmod && (op5 == op5_divu);
  assign inst_modu  = grp_divmod && (op5 == op5_modu);
  assign inst_slli  = grp_shift && (op5 == op5_slli);
  assign inst_srli  = grp_shift && (op5 == op5_srli);
  assign inst_srai  = grp_shift && (op5 == op5_srai);

  assign inst_slti  = grp_alu && (op4 == op4_slti);
  assign inst_sltui = grp_alu && (op4 == op4_sltui);
  assign inst_addi  = grp_alu && (op4 == op4_addi);
  assign inst_andi  = grp_alu && (op4 == op4_andi);
  assign inst_ori   = grp_alu && (op4 == op4_ori);
  assign inst_xori  = grp_alu && (op4 == op4_xori);

  assign inst_ld_b  = grp_mem && (op4 == op4_ld_b);
  assign inst_ld_h  = grp_mem && (op4 == op4_ld_h);
  assign inst_ld_w  = grp_mem && (op4 == op4_ld_w);
  assign inst_ld_bu = grp_mem && (op4 == op4_ld_bu);
  assign inst_ld_hu = grp_mem && (op4 == op4_ld_hu);
  assign inst_st_b  = grp_mem && (op4 == op4_st_b);
  assign inst_st_h  = grp_mem && (op4 == op4_st_h);
  assign inst_st_w  = grp_mem && (op4 == op4_st_w);

  assign inst_lu12i     = (op6 == op6_lu12i) && !inst[25];
  assign inst_pcaddu12i = (op6 == op6_pcaddu12i) && !inst[25];
  assign inst_jirl      = op6 == op6_jirl;
  assign inst_b         = op6 == op6_b;
  assign inst_bl        = op6 == op6_bl;
  assign cond_br        = (op6 >= op6_beq) && (op6 <= op6_bgeu); // beq..bgeu are contiguous

  assign is_load   = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
  assign is_store  = inst_st_b | inst_st_h | inst_st_w;
  assign need_si12 = inst_slli | inst_srli | inst_srai | inst_addi | inst_slti | inst_sltui
                   | is_load | is_store;
  assign need_si20 = inst_lu12i | inst_pcaddu12i;
  assign src2_is_4 = inst_jirl | inst_bl; // link value pc+4

  always_comb begin
    ctrl.alu_op            = '0;
    ctrl.alu_op[alu_add]   = inst_add | inst_addi | is_load | is_store | inst_jirl | inst_bl
                           | inst_pcaddu12i;
    ctrl.alu_op[alu_sub]   = inst_sub | (op6 == op6_beq) | (op6 == op6_bne);
    ctrl.alu_op[alu_slt]   = inst_slt | inst_slti | (op6 == op6_blt) | (op6 == op6_bge);
    ctrl.alu_op[alu_sltu]  = inst_sltu | inst_sltui | (op6 == op6_bltu) | (op6 == op6_bgeu);
    ctrl.alu_op[alu_and]   = inst_and | inst_andi;
    ctrl.alu_op[alu_nor]   = inst_nor;
    ctrl.alu_op[alu_or]    = inst_or | inst_ori;
    ctrl.alu_op[alu_xor]   = inst_xor | inst_xori;
    ctrl.alu_op[alu_sll]   = inst_sll | inst_slli;
    ctrl.alu_op[alu_srl]   = inst_srl | inst_srli;
    ctrl.alu_op[alu_sra]   = inst_sra | inst_srai;
    ctrl.alu_op[alu_lui]   = inst_lu12i;
    ctrl.alu_op[alu_mul]   = inst_mul;
    ctrl.alu_op[alu_mulh]  = inst_mulh;
    ctrl.alu_op[alu_mulhu] = inst_mulhu;
    ctrl.alu_op[alu_div]   = inst_div;
    ctrl.alu_op[alu_divu]  = inst_divu;
    ctrl.alu_op[alu_mod]   = inst_mod;
    ctrl.alu_op[alu_modu]  = inst_modu;

    ctrl.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    ctrl.src2_is_imm = need_si12 | need_si20 | src2_is_4 | inst_andi | inst_ori | inst_xori;

    if (src2_is_4) ctrl.imm = 32'd4;
    else if (need_si20) ctrl.imm = {i20, 12'b0};
    else if (need_si12) ctrl.imm = {{20{i12[11]}}, i12};
    else ctrl.imm = {20'b0, i12}; // logic immediates

    ctrl.rf_raddr1    = rj;
    ctrl.rf_raddr2    = (is_store | cond_br) ? rd : rk; // rd holds store data / compare operand
    ctrl.rf_we        = !(is_store | inst_b | cond_br);
    ctrl.dest         = inst_bl ? 5'd1 : rd;
    ctrl.mem_op       = {inst_st_w, inst_st_h, inst_st_b, inst_ld_w,
                         inst_ld_b, inst_ld_h, inst_ld_bu, inst_ld_hu};
    ctrl.res_from_mem = is_load;

    case (op6)
      op6_jirl: ctrl.branch_kind = br_jirl;
      op6_b:    ctrl.branch_kind = br_b;
      op6_bl:   ctrl.branch_kind = br_bl;
      op6_beq:  ctrl.branch_kind = br_beq;
      op6_bne:  ctrl.branch_kind = br_bne;
      op6_blt:  ctrl.branch_kind = br_blt;
      op6_bge:  ctrl.branch_kind = br_bge;
      op6_bltu: ctrl.branch_kind = br_bltu;
      op6_bgeu: ctrl.branch_kind = br_bgeu;
      default:  ctrl.branch_kind = br_none;
    endcase

    ctrl.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b00}
                                      : {{14{i16[15]}}, i16, 2'b00};
  end

endmodule

/* source/operand_bypass.sv */
`timescale 1ns/10ps
module operand_bypass (
  input  decode_pkg::reg_addr_t  raddr1,
  input  decode_pkg::reg_addr_t  raddr2,
  input  logic                   need1,
  input  logic                   need2,
  input  decode_pkg::word_t      rdata1,
  input  decode_pkg::word_t      rdata2,
  input  decode_pkg::ex_bypass_t ex_fwd,
  input  decode_pkg::bypass_t    mem_fwd,
  input  decode_pkg::bypass_t    wb_fwd,
  output decode_pkg::word_t      rj_value,
  output decode_pkg::word_t      rkd_value,
  output logic                   stall
);
  import decode_pkg::*;

  logic ex_hit1;
  logic ex_hit2;

  function automatic logic hits(input reg_addr_t addr, input bypass_t src);
    return (addr != '0) && src.rf_we && (addr == src.waddr);
  endfunction

  // youngest producer wins
  function automatic word_t pick(input reg_addr_t addr, input word_t raw,
                                 input bypass_t ex, input bypass_t mem, input bypass_t wb);
    if (hits(addr, ex)) return ex.wdata;
    if (hits(addr, mem)) return mem.wdata;
    if (hits(addr, wb)) return wb.wdata;
    return raw;
  endfunction

  assign ex_hit1 = hits(raddr1, ex_fwd.wr);
  assign ex_hit2 = hits(raddr2, ex_fwd.wr);

  assign rj_value  = pick(raddr1, rdata1, ex_fwd.wr, mem_fwd, wb_fwd);
  assign rkd_value = pick(raddr2, rdata2, ex_fwd.wr, mem_fwd, wb_fwd);

  // load in EX has no data yet
  assign stall = ex_fwd.res_from_mem && ((ex_hit1 && need1) || (ex_hit2 && need2));

endmodule

/* source/register_file.sv */
`timescale 1ns/10ps
module register_file (
  input  logic                  clk,
  input  decode_pkg::reg_addr_t raddr1,
  output decode_pkg::word_t     rdata1,
  input  decode_pkg::reg_addr_t raddr2,
  output decode_pkg::word_t     rdata2,
  input  decode_pkg::bypass_t   wr
);
  import decode_pkg::*;

  word_t regs [32];

  // writes to r0 land in the array but never read back
  always_ff @(posedge clk) begin
    if (wr.rf_we) begin
      regs[wr.waddr] <= wr.wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* test/decode_stage_assertions.sv */
`timescale 1ns/10ps
module decode_stage_assertions (
  input logic                    clk,
  input logic                    resetn,
  input logic                    id_valid,
  input logic                    ex_valid,
  input logic                    stall,
  input decode_pkg::branch_req_t branch
);

  // nothing leaves decode while a load result is pending
  stalled_instruction_held: assert property (
    @(posedge clk) disable iff (!resetn) id_valid && stall |=> id_valid
  ) else $error("stalled instruction dropped from decode");

  // wrong-path slot squashed
  no_valid_after_taken: assert property (
    @(posedge clk) disable iff (!resetn) branch.taken |=> !ex_valid
  ) else $error("ex_valid high in the cycle after a taken branch");

endmodule

/* test/decode_stage_tb.sv */
`timescale 1ns/10ps
module decode_stage_tb;
  import decode_pkg::*;

  typedef struct {
    word_t       inst;
    word_t       pc;
    ex_bypass_t  ex;
    bypass_t     mem;
    bypass_t     wb;
    logic        bp;      // hold ex_allowin low for a while
    logic        is_br;
    ex_bundle_t  exp;
    branch_req_t bexp;
  } row_t;

  logic          clk = 1'b0;
  logic          resetn;
  logic          fe_valid;
  fetch_bundle_t fe_bundle;
  logic          allowin;
  logic          ex_allowin;
  logic          ex_valid;
  ex_bundle_t    ex_bundle;
  branch_req_t   branch;
  ex_bypass_t    ex_fwd;
  bypass_t       mem_fwd;
  bypass_t       wb_fwd;

  row_t        rows[$];
  word_t       rv[32];   // shadow register file
  ex_bypass_t  cur_ex = '0;
  bypass_t     cur_mem = '0;
  bypass_t     cur_wb = '0;
  logic        cur_bp = 1'b0;
  word_t       cur_pc = 32'h1c00_0000;
  logic [31:0] lfsr_state = 32'h86faa1e4;

  decode_stage decode_stage_inst (.*);

  bind decode_stage decode_stage_assertions assertions_inst (
    .clk      (clk),
    .resetn   (resetn),
    .id_valid (id_valid),
    .ex_valid (ex_valid),
    .stall    (stall),
    .branch   (branch)
  );

  always #4 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic word_t lfsr_bits(input int n);
    word_t w;
    logic  fb;
    w = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic word_t sx12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t boff16(input logic [15:0] v);
    return {{14{v[15]}}, v, 2'b00};
  endfunction

  function automatic word_t boff26(input logic [25:0] v);
    return {{4{v[25]}}, v, 2'b00};
  endfunction

  function automatic word_t r3(input logic [1:0] op2, input logic [4:0] op5,
                               input reg_addr_t rk, input reg_addr_t rj, input reg_addr_t rd);
    return {op6_alu, op4_reg, op2, op5, rk, rj, rd};
  endfunction

  function automatic word_t ri12(input logic [5:0] op6, input logic [3:0] op4,
                                 input logic [11:0] i12, input reg_addr_t rj, input reg_addr_t rd);
    return {op6, op4, i12, rj, rd};
  endfunction

  function automatic word_t ri16(input logic [5:0] op6, input logic [15:0] i16,
                                 input reg_addr_t rj, input reg_addr_t rd);
    return {op6, i16, rj, rd};
  endfunction

  function automatic word_t ri20(input logic [5:0] op6, input logic [19:0] i20,
                                 input reg_addr_t rd);
    return {op6, 1'b0, i20, rd};
  endfunction

  function automatic word_t ri26(input logic [5:0] op6, input logic [25:0] i26);
    return {op6, i26[15:0], i26[25:16]}; // high offset bits sit at the bottom
  endfunction

  // operand as seen by decode, youngest producer first
  function automatic word_t val(input reg_addr_t a);
    if (a == '0) return '0;
    if (cur_ex.wr.rf_we && cur_ex.wr.waddr == a) return cur_ex.wr.wdata;
    if (cur_mem.rf_we && cur_mem.waddr == a) return cur_mem.wdata;
    if (cur_wb.rf_we && cur_wb.waddr == a) return cur_wb.wdata;
    return rv[a];
  endfunction

  function automatic logic cond_taken(input logic [5:0] op6, input word_t a, input word_t b);
    case (op6)
      op6_beq:  return a == b;
      op6_bne:  return a != b;
      op6_blt:  return $signed(a) < $signed(b);
      op6_bge:  return $signed(a) >= $signed(b);
      op6_bltu: return a < b;
      op6_bgeu: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  task automatic add_row(input word_t inst, input int alu_bit, input logic s1pc,
                         input logic s2imm, input word_t imm, input logic r2_is_rd,
                         input reg_addr_t waddr, input logic we, input logic [7:0] mop,
                         input logic br, input logic taken, input word_t target);
    row_t      r;
    reg_addr_t r2;
    r2 = r2_is_rd ? inst[4:0] : inst[14:10];
    r.inst = inst;
    r.pc = cur_pc;
    r.ex = cur_ex;
    r.mem = cur_mem;
    r.wb = cur_wb;
    r.bp = cur_bp;
    r.is_br = br;
    r.exp.alu_op = (alu_bit < 0) ? '0 : alu_op_t'(1) << alu_bit;
    r.exp.res_from_mem = |mop[4:0];
    r.exp.alu_src1 = s1pc ? cur_pc : val(inst[9:5]);
    r.exp.alu_src2 = s2imm ? imm : val(r2);
    r.exp.mem_op = mem_op_t'(mop);
    r.exp.rf_we = we;
    r.exp.rf_waddr = waddr;
    r.exp.rkd_value = val(r2);
    r.exp.pc = cur_pc;
    r.bexp.stall = 1'b0;
    r.bexp.taken = br & taken;
    r.bexp.target = br ? target : cur_pc + boff16(inst[25:10]);
    rows.push_back(r);
    if (cur_wb.rf_we && cur_wb.waddr != '0) rv[cur_wb.waddr] = cur_wb.wdata;
    cur_pc = cur_pc + 4;
  endtask

  task automatic alu_reg(input logic [1:0] op2, input logic [4:0] op5, input int alu_bit);
    add_row(r3(op2, op5, 5'd3, 5'd2, 5'd4), alu_bit, 1'b0, 1'b0, '0, 1'b0, 5'd4, 1'b1,
            8'h00, 1'b0, 1'b0, '0);
  endtask

  task automatic imm_row(input word_t inst, input int alu_bit, input logic s1pc,
                         input word_t imm);
    add_row(inst, alu_bit, s1pc, 1'b1, imm, 1'b0, inst[4:0], 1'b1, 8'h00, 1'b0, 1'b0, '0);
  endtask

  task automatic mem_row(input word_t inst, input logic [7:0] mop);
    add_row(inst, alu_add, 1'b0, 1'b1, sx12(inst[21:10]), |mop[7:5], inst[4:0], ~|mop[7:5],
            mop, 1'b0, 1'b0, '0);
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic check_bundle(input ex_bundle_t got, input ex_bundle_t exp);
    if (got !== exp) fail_run($sformatf("error: ex_bundle got %h expected %h", got, exp));
  endtask

  task automatic check_branch(input branch_req_t got, input branch_req_t exp);
    if (got !== exp) fail_run($sformatf("error: branch got %h expected %h", got, exp));
  endtask

  task automatic check_status(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic wait_allowin();
    int n;
    n = 0;
    while (allowin !== 1'b1 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (allowin !== 1'b1) fail_run("timeout: decode stage never raised allowin");
  endtask

  task automatic apply_row(input row_t r);
    wait_allowin();
    @(posedge clk);
    fe_valid <= 1'b1;
    fe_bundle <= '{pc: r.pc, inst: r.inst};
    ex_fwd <= r.ex;
    mem_fwd <= r.mem;
    wb_fwd <= r.wb;
    ex_allowin <= !r.bp;
    @(posedge clk);    // accepting edge
    fe_valid <= r.bp || r.bexp.taken; // younger fetch waiting behind this one
    fe_bundle <= '{pc: r.pc + 32'd4, inst: ~r.inst};
    @(negedge clk);
    if (r.ex.res_from_mem) begin
      check_status("ex_valid", ex_valid, 1'b0);
      check_status("allowin", allowin, 1'b0);
      check_branch(branch, '{stall: r.is_br, taken: 1'b0, target: r.bexp.target});
      @(posedge clk);
      ex_fwd.res_from_mem <= 1'b0; // load data arrives
      @(negedge clk);
    end
    if (r.bp) begin
      repeat (3) begin
        check_status("allowin", allowin, 1'b0);
        check_status("ex_valid", ex_valid, 1'b1);
        check_bundle(ex_bundle, r.exp);
        @(negedge clk);
      end
      @(posedge clk);
      ex_allowin <= 1'b1;
      fe_valid <= 1'b0;
      @(negedge clk);
    end
    check_status("ex_valid", ex_valid, 1'b1);
    check_status("allowin", allowin, 1'b1);
    check_bundle(ex_bundle, r.exp);
    check_branch(branch, r.bexp);
    @(posedge clk);
    fe_valid <= 1'b0;
    ex_fwd <= '0;
    mem_fwd <= '0;
    wb_fwd <= '0;
    @(negedge clk);
    check_status("ex_valid after leaving", ex_valid, 1'b0);
  endtask

  initial begin
    logic [5:0]  op6v;
    logic [15:0] off;
    logic [25:0] off26;
    word_t       w;
    reg_addr_t   rj;
    reg_addr_t   rd;
    resetn = 1'b0;
    fe_valid = 1'b0;
    fe_bundle = '0;
    ex_allowin = 1'b1;
    ex_fwd = '0;
    mem_fwd = '0;
    wb_fwd = '0;
    rv[0] = '0;
    repeat (8) begin
      @(negedge clk);
      check_status("ex_valid in reset", ex_valid, 1'b0);
      check_status("branch.taken in reset", branch.taken, 1'b0);
      check_status("allowin in reset", allowin, 1'b1);
    end
    @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    check_status("ex_valid after reset", ex_valid, 1'b0);
    check_status("branch.taken after reset", branch.taken, 1'b0);
    check_status("allowin after reset", allowin, 1'b1);

    for (int r = 1; r < 32; r++) begin
      @(posedge clk);
      rv[r] = lfsr_bits(32);
      wb_fwd <= '{rf_we: 1'b1, waddr: reg_addr_t'(r), wdata: rv[r]};
    end
    @(posedge clk);
    wb_fwd <= '0;
    @(negedge clk);

    alu_reg(op2_reg3, op5_add, alu_add);
    alu_reg(op2_reg3, op5_sub, alu_sub);
    alu_reg(op2_reg3, op5_slt, alu_slt);
    alu_reg(op2_reg3, op5_sltu, alu_sltu);
    alu_reg(op2_reg3, op5_nor, alu_nor);
    alu_reg(op2_reg3, op5_and, alu_and);
    alu_reg(op2_reg3, op5_or, alu_or);
    alu_reg(op2_reg3, op5_xor, alu_xor);
    alu_reg(op2_reg3, op5_sll, alu_sll);
    alu_reg(op2_reg3, op5_srl, alu_srl);
    alu_reg(op2_reg3, op5_sra, alu_sra);
    alu_reg(op2_reg3, op5_mul, alu_mul);
    alu_reg(op2_reg3, op5_mulh, alu_mulh);
    alu_reg(op2_reg3, op5_mulhu, alu_mulhu);
    alu_reg(op2_divmod, op5_div, alu_div);
    alu_reg(op2_divmod, op5_mod, alu_mod);
    alu_reg(op2_divmod, op5_divu, alu_divu);
    alu_reg(op2_divmod, op5_modu, alu_modu);
    imm_row(ri12(op6_alu, op4_shift, {op2_shift, op5_slli, 5'd7}, 5'd6, 5'd8), alu_sll,
            1'b0, sx12({op2_shift, op5_slli, 5'd7}));
    imm_row(ri12(op6_alu, op4_shift, {op2_shift, op5_srli, 5'd9}, 5'd6, 5'd8), alu_srl,
            1'b0, sx12({op2_shift, op5_srli, 5'd9}));
    imm_row(ri12(op6_alu, op4_shift, {op2_shift, op5_srai, 5'd31}, 5'd6, 5'd8), alu_sra,
            1'b0, sx12({op2_shift, op5_srai, 5'd31}));
    imm_row(ri12(op6_alu, op4_addi, 12'hf80, 5'd10, 5'd9), alu_add, 1'b0, sx12(12'hf80));
    imm_row(ri12(op6_alu, op4_slti, 12'h801, 5'd10, 5'd9), alu_slt, 1'b0, sx12(12'h801));
    imm_row(ri12(op6_alu, op4_sltui, 12'h7ff, 5'd10, 5'd9), alu_sltu, 1'b0, sx12(12'h7ff));
    imm_row(ri12(op6_alu, op4_andi, 12'hf0f, 5'd10, 5'd9), alu_and, 1'b0, 32'h0000_0f0f);
    imm_row(ri12(op6_alu, op4_ori, 12'h8a5, 5'd10, 5'd9), alu_or, 1'b0, 32'h0000_08a5);
    imm_row(ri12(op6_alu, op4_xori, 12'hfff, 5'd10, 5'd9), alu_xor, 1'b0, 32'h0000_0fff);
    imm_row(ri20(op6_lu12i, 20'habcde, 5'd11), alu_lui, 1'b0, 32'habcd_e000);
    imm_row(ri20(op6_pcaddu12i, 20'h80001, 5'd11), alu_add, 1'b1, 32'h8000_1000);
    mem_row(ri12(op6_mem, op4_ld_w, 12'h804, 5'd7, 5'd12), 8'h10);
    mem_row(ri12(op6_mem, op4_ld_b, 12'h013, 5'd7, 5'd12), 8'h08);
    mem_row(ri12(op6_mem, op4_ld_h, 12'hffe, 5'd7, 5'd12), 8'h04);
    mem_row(ri12(op6_mem, op4_ld_bu, 12'h001, 5'd7, 5'd12), 8'h02);
    mem_row(ri12(op6_mem, op4_ld_hu, 12'h002, 5'd7, 5'd12), 8'h01);
    mem_row(ri12(op6_mem, op4_st_w, 12'h100, 5'd7, 5'd13), 8'h80);
    mem_row(ri12(op6_mem, op4_st_h, 12'h802, 5'd7, 5'd13), 8'h40);
    mem_row(ri12(op6_mem, op4_st_b, 12'h003, 5'd7, 5'd13), 8'h20);

    // same register from all three later stages
    cur_ex = '{1'b0, '{1'b1, 5'd2, 32'h1111_1111}};
    cur_mem = '{1'b1, 5'd2, 32'h2222_2222};
    cur_wb = '{1'b1, 5'd2, 32'h3333_3333};
    alu_reg(op2_reg3, op5_add, alu_add);
    cur_ex.wr.rf_we = 1'b0;
    alu_reg(op2_reg3, op5_add, alu_add);
    cur_mem.rf_we = 1'b0;
    alu_reg(op2_reg3, op5_add, alu_add);
    cur_ex = '{1'b0, '{1'b1, 5'd0, 32'h1111_1111}};
    cur_mem = '{1'b1, 5'd0, 32'h2222_2222};
    cur_wb = '{1'b1, 5'd0, 32'h3333_3333};
    add_row(r3(op2_reg3, op5_add, 5'd3, 5'd0, 5'd4), alu_add, 1'b0, 1'b0, '0, 1'b0, 5'd4,
            1'b1, 8'h00, 1'b0, 1'b0, '0);
    cur_mem = '0;
    cur_wb = '0;

    // load in EX feeding a needed operand
    cur_ex = '{1'b1, '{1'b1, 5'd3, 32'h4444_4444}};
    alu_reg(op2_reg3, op5_or, alu_or);
    add_row(ri16(op6_beq, 16'h0010, 5'd3, 5'd5), alu_sub, 1'b0, 1'b0, '0, 1'b1, 5'd5, 1'b0,
            8'h00, 1'b1, cond_taken(op6_beq, val(5'd3), val(5'd5)), cur_pc + boff16(16'h0010));
    cur_ex = '0;

    for (int k = 0; k < 6; k++) begin
      op6v = op6_beq + 6'(k);
      for (int p = 0; p < 2; p++) begin
        rj = (p == 0) ? 5'd12 : 5'd14;
        rd = (p == 0) ? 5'd13 : 5'd14; // second pass compares equal operands
        w = lfsr_bits(16);
        off = w[15:0];
        add_row(ri16(op6v, off, rj, rd), (k < 2) ? alu_sub : (k < 4) ? alu_slt : alu_sltu,
                1'b0, 1'b0, '0, 1'b1, rd, 1'b0, 8'h00, 1'b1,
                cond_taken(op6v, val(rj), val(rd)), cur_pc + boff16(off));
      end
    end
    w = lfsr_bits(26);
    off26 = w[25:0];
    add_row(ri26(op6_b, off26), -1, 1'b0, 1'b0, '0, 1'b0, off26[20:16], 1'b0, 8'h00, 1'b1,
            1'b1, cur_pc + boff26(off26));
    w = lfsr_bits(26);
    off26 = w[25:0];
    add_row(ri26(op6_bl, off26), alu_add, 1'b1, 1'b1, 32'd4, 1'b0, 5'd1, 1'b1, 8'h00, 1'b1,
            1'b1, cur_pc + boff26(off26));
    w = lfsr_bits(16);
    off = w[15:0];
    add_row(ri16(op6_jirl, off, 5'd15, 5'd16), alu_add, 1'b1, 1'b1, 32'd4, 1'b0, 5'd16, 1'b1,
            8'h00, 1'b1, 1'b1, val(5'd15) + boff16(off));

    cur_bp = 1'b1;
    alu_reg(op2_reg3, op5_xor, alu_xor);
    cur_bp = 1'b0;

    foreach (rows[i]) apply_row(rows[i]);
    $display("Verification passed");
    $finish;
  end

endmodule
